// File: project.f
+incdir+tests
common/lbp_pkg.sv
common/bus_pkg.sv
lbp/lbp_window.sv
lbp/lbp_scanner.sv
logic/mem_arbiter.sv
logic/simple_ram.sv
logic/apb_host_port.sv
logic/lbp_top.sv
tests/tb_lbp.sv

// File: Makefile
# Verilator simulation of the LBP subsystem testbench.

TOP := tb_lbp

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP) and search sim.log for the pass line"
	@echo "make clean  remove obj_dir and sim.log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module $(TOP) -Mdir obj_dir -f project.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "TEST PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/lbp_ref.svh
`ifndef LBP_REF_SVH
`define LBP_REF_SVH

// register values the host should see in each phase of a run.
localparam logic [31:0] EXP_STATUS_IDLE = 32'd0;
localparam logic [31:0] EXP_STATUS_DONE = 32'd2;
localparam logic [31:0] EXP_SIZE        = 32'(IMG_BITS);

// copy of the image as it was written into the gray region.
lbp_pkg::pixel_t ref_img [PIXELS];

// neighbours are taken in raster order around the centre, so bit 0 is top-left
// and bit 7 is bottom-right.
function automatic lbp_pkg::code_t ref_code(input int r, input int c);
    lbp_pkg::code_t  code;
    lbp_pkg::pixel_t ctr;
    int              bit_n;
    code  = '0;
    bit_n = 0;
    if ((r == 0) || (c == 0) || (r == SIDE - 1) || (c == SIDE - 1))
        return code;
    ctr = ref_img[r * SIDE + c];
    for (int dr = -1; dr <= 1; dr++)
    begin
        for (int dc = -1; dc <= 1; dc++)
        begin
            if ((dr != 0) || (dc != 0))
            begin
                code[bit_n] = ref_img[(r + dr) * SIDE + c + dc] >= ctr;
                bit_n++;
            end
        end
    end
    return code;
endfunction

`endif

// File: tests/tb_lbp.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lbp;

    localparam int IMG_BITS = 4;
    localparam int SIDE     = 1 << IMG_BITS;
    localparam int PIXELS   = SIDE * SIDE;
    localparam int PERIOD   = 40;
    localparam int RUNS     = 3;
    // about eight APB transfers of up to eight cycles each for every pixel.
    localparam int APB_CYCLES = 8 * 8 * PIXELS;
    localparam int TIMEOUT    = (RUNS * PIXELS * 40 + APB_CYCLES) * PERIOD;

    logic              clk;
    logic              reset;
    bus_pkg::apb_req_t apb;
    bus_pkg::apb_rsp_t apb_rsp;
    logic              done;

    logic [15:0] lfsr_state;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          done_rises;
    logic        done_prev;

    `include "lbp_ref.svh"

    lbp_top #(.IMG_BITS(IMG_BITS)) dut (
        .clk     (clk),
        .reset   (reset),
        .apb     (apb),
        .apb_rsp (apb_rsp),
        .done    (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // done is sampled on the falling edge, away from the edge that moves it.
    always @(negedge clk)
    begin
        if (done && !done_prev)
            done_rises++;
        done_prev = done;
    end

    initial
    begin
        #(TIMEOUT);
        $display("watchdog expired after %0d ns before the tests finished", TIMEOUT);
        $display("TEST FAIL");
        $finish;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    function automatic logic [15:0] pixel_addr(input logic [1:0] region, input int idx);
        return {region, 14'(idx)};
    endfunction

    function automatic logic [15:0] reg_addr(input logic [1:0] num);
        return {bus_pkg::REGION_REGS, 12'd0, num};
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s got %08h expected %08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_code(input string name, input lbp_pkg::code_t got,
                              input lbp_pkg::code_t exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s got %02h expected %02h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("MISMATCH %s got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    // one setup cycle, then the access phase is held until pready is seen.
    task automatic bus_transfer(input logic write, input logic [15:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk);
        apb.psel    = 1'b1;
        apb.penable = 1'b0;
        apb.pwrite  = write;
        apb.paddr   = addr;
        apb.pwdata  = wdata;
        @(negedge clk);
        apb.penable = 1'b1;
        #(PERIOD / 4);
        while (!apb_rsp.pready)
        begin
            @(negedge clk);
            #(PERIOD / 4);
        end
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(negedge clk);
        apb = '0;
    endtask

    task automatic read_word(input logic [15:0] addr, output logic [31:0] data);
        logic err;
        bus_transfer(1'b0, addr, '0, data, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic write_word(input logic [15:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        logic        err;
        bus_transfer(1'b1, addr, data, ignored, err);
        check_flag("pslverr", err, 1'b0);
    endtask

    task automatic load_image();
        for (int i = 0; i < PIXELS; i++)
        begin
            ref_img[i] = lbp_pkg::pixel_t'(rand_bits(8));
            write_word(pixel_addr(bus_pkg::REGION_GRAY, i), 32'(ref_img[i]));
        end
    endtask

    task automatic check_all_codes();
        logic [31:0] data;
        for (int r = 0; r < SIDE; r++)
        begin
            for (int c = 0; c < SIDE; c++)
            begin
                read_word(pixel_addr(bus_pkg::REGION_CODE, r * SIDE + c), data);
                check_code($sformatf("code[%0d][%0d]", r, c), lbp_pkg::code_t'(data[7:0]),
                           ref_code(r, c));
            end
        end
    endtask

    // starts a scan and polls STATUS until done, optionally reading gray pixels
    // between polls or writing CTRL again once busy has been seen.
    task automatic run_scan(input logic probe_gray, input logic restart);
        logic [31:0] status;
        logic [31:0] data;
        int          idx;
        int          polls;
        polls = 0;
        write_word(reg_addr(bus_pkg::REG_CTRL), 32'd1);
        read_word(reg_addr(bus_pkg::REG_STATUS), status);
        while (!status[1])
        begin
            check_flag("status.busy", status[0], 1'b1);
            polls++;
            if (restart && (polls == 1))
                write_word(reg_addr(bus_pkg::REG_CTRL), 32'd1);
            if (probe_gray)
            begin
                idx = int'(rand_bits(2 * IMG_BITS));
                read_word(pixel_addr(bus_pkg::REGION_GRAY, idx), data);
                check_word($sformatf("gray[%0d]", idx), data, 32'(ref_img[idx]));
            end
            read_word(reg_addr(bus_pkg::REG_STATUS), status);
        end
        if (polls == 0)
        begin
            $display("scan finished before any STATUS read showed it busy");
            errors++;
        end
        check_word("status", status, EXP_STATUS_DONE);
        check_flag("done", done, 1'b1);
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before)
            $display("test %0d %s: ok", num, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", num, name, errors - errors_before);
        end
    endtask

    initial
    begin
        logic [31:0] data;
        logic        err;
        int          mark;
        int          rises;
        apb          = '0;
        reset        = 1'b1;
        lfsr_state   = 16'h0001;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        done_rises   = 0;
        done_prev    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        mark = errors;
        check_flag("done", done, 1'b0);
        check_flag("pready", apb_rsp.pready, 1'b0);
        read_word(reg_addr(bus_pkg::REG_STATUS), data);
        check_word("status", data, EXP_STATUS_IDLE);
        read_word(reg_addr(bus_pkg::REG_SIZE), data);
        check_word("size", data, EXP_SIZE);
        report_test(1, "reset values", mark);

        mark = errors;
        load_image();
        for (int i = 0; i < PIXELS; i++)
        begin
            read_word(pixel_addr(bus_pkg::REGION_GRAY, i), data);
            check_word($sformatf("gray[%0d]", i), data, 32'(ref_img[i]));
        end
        report_test(2, "gray readback", mark);

        mark = errors;
        run_scan(1'b0, 1'b0);
        check_all_codes();
        report_test(3, "first scan", mark);

        mark = errors;
        load_image();
        run_scan(1'b1, 1'b0);
        check_all_codes();
        report_test(4, "scan with host traffic", mark);

        // a second start would make STATUS show busy again within this window.
        mark  = errors;
        rises = done_rises;
        run_scan(1'b0, 1'b1);
        repeat (PIXELS) @(negedge clk);
        read_word(reg_addr(bus_pkg::REG_STATUS), data);
        check_word("status", data, EXP_STATUS_DONE);
        if (done_rises - rises != 1)
        begin
            $display("done rose %0d times during one run instead of once", done_rises - rises);
            errors++;
        end
        check_all_codes();
        report_test(5, "start while busy", mark);

        mark = errors;
        bus_transfer(1'b0, pixel_addr(bus_pkg::REGION_BAD, 5), '0, data, err);
        check_flag("pslverr", err, 1'b1);
        bus_transfer(1'b1, pixel_addr(bus_pkg::REGION_BAD, 5), 32'hff, data, err);
        check_flag("pslverr", err, 1'b1);
        bus_transfer(1'b1, pixel_addr(bus_pkg::REGION_CODE, SIDE + 1), 32'(~ref_code(1, 1)),
                     data, err);
        check_flag("pslverr", err, 1'b1);
        read_word(pixel_addr(bus_pkg::REGION_CODE, SIDE + 1), data);
        check_code("code[1][1]", lbp_pkg::code_t'(data[7:0]), ref_code(1, 1));
        report_test(6, "bus errors", mark);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/lbp_top.sv
`timescale 1ns/1ns
`default_nettype none

module lbp_top #(
    parameter int IMG_BITS = 7
) (
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::apb_req_t apb,
    output bus_pkg::apb_rsp_t apb_rsp,
    output logic              done
);

    logic start;
    logic busy;

    bus_pkg::mem_req_t host_gray_req;
    bus_pkg::mem_rsp_t host_gray_rsp;
    bus_pkg::mem_req_t host_code_req;
    bus_pkg::mem_rsp_t host_code_rsp;
    bus_pkg::mem_req_t scan_fetch_req;
    bus_pkg::mem_rsp_t scan_fetch_rsp;
    bus_pkg::mem_req_t scan_code_req;
    bus_pkg::mem_rsp_t scan_code_rsp;
    bus_pkg::mem_req_t gray_mem;
    bus_pkg::mem_req_t code_mem;
    lbp_pkg::pixel_t   gray_rdata;
    lbp_pkg::pixel_t   code_rdata;

    apb_host_port #(.IMG_BITS(IMG_BITS)) host_port (
        .clk       (clk),
        .reset     (reset),
        .apb       (apb),
        .apb_rsp   (apb_rsp),
        .start     (start),
        .busy      (busy),
        .done_flag (done),
        .gray_req  (host_gray_req),
        .gray_rsp  (host_gray_rsp),
        .code_req  (host_code_req),
        .code_rsp  (host_code_rsp)
    );

    lbp_scanner #(.IMG_BITS(IMG_BITS)) scanner (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .fetch_req (scan_fetch_req),
        .fetch_rsp (scan_fetch_rsp),
        .code_req  (scan_code_req),
        .code_rsp  (scan_code_rsp)
    );

    mem_arbiter gray_arb (
        .clk       (clk),
        .reset     (reset),
        .req0      (host_gray_req),
        .req1      (scan_fetch_req),
        .rsp0      (host_gray_rsp),
        .rsp1      (scan_fetch_rsp),
        .mem       (gray_mem),
        .mem_rdata (gray_rdata)
    );

    mem_arbiter code_arb (
        .clk       (clk),
        .reset     (reset),
        .req0      (host_code_req),
        .req1      (scan_code_req),
        .rsp0      (host_code_rsp),
        .rsp1      (scan_code_rsp),
        .mem       (code_mem),
        .mem_rdata (code_rdata)
    );

    simple_ram #(.IMG_BITS(IMG_BITS)) gray_ram (
        .clk   (clk),
        .mem   (gray_mem),
        .rdata (gray_rdata)
    );

    simple_ram #(.IMG_BITS(IMG_BITS)) code_ram (
        .clk   (clk),
        .mem   (code_mem),
        .rdata (code_rdata)
    );

endmodule

`default_nettype wire

// File: logic/apb_host_port.sv
`timescale 1ns/1ns
`default_nettype none

module apb_host_port #(
    parameter int IMG_BITS = 7
) (
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::apb_req_t apb,
    output bus_pkg::apb_rsp_t apb_rsp,
    output logic              start,
    input  logic              busy,
    input  logic              done_flag,
    output bus_pkg::mem_req_t gray_req,
    input  bus_pkg::mem_rsp_t gray_rsp,
    output bus_pkg::mem_req_t code_req,
    input  bus_pkg::mem_rsp_t code_rsp
);

    bus_pkg::apb_addr_u addr_u;
    bus_pkg::mem_rsp_t  sel_rsp;
    logic [1:0]         region;
    logic               access;
    logic               bad_access;
    logic               reg_access;
    logic               mem_req;
    logic               rd_wait;
    logic [31:0]        reg_rdata;

    assign addr_u = apb.paddr;
    assign region = addr_u.pix.region;
    assign access = apb.psel && apb.penable;

    // the code region is read-only from the bus side.
    assign bad_access = (region == bus_pkg::REGION_BAD) ||
                        ((region == bus_pkg::REGION_CODE) && apb.pwrite);
    assign reg_access = region == bus_pkg::REGION_REGS;

    assign sel_rsp = (region == bus_pkg::REGION_GRAY) ? gray_rsp : code_rsp;

    // requests are raised in the access phase and dropped once granted.
    assign gray_req.req   = access && (region == bus_pkg::REGION_GRAY) && !rd_wait;
    assign gray_req.we    = apb.pwrite;
    assign gray_req.addr  = addr_u.pix.idx;
    assign gray_req.wdata = apb.pwdata[7:0];

    assign code_req.req   = access && (region == bus_pkg::REGION_CODE) && !apb.pwrite &&
                            !rd_wait;
    assign code_req.we    = 1'b0;
    assign code_req.addr  = addr_u.pix.idx;
    assign code_req.wdata = '0;

    assign mem_req = gray_req.req || code_req.req;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            rd_wait <= 1'b0;
            start   <= 1'b0;
        end
        else
        begin
            if (rd_wait && sel_rsp.rvalid)
                rd_wait <= 1'b0;
            else if (mem_req && sel_rsp.gnt && !apb.pwrite)
                rd_wait <= 1'b1;

            start <= access && reg_access && apb.pwrite &&
                     (addr_u.regs.num == bus_pkg::REG_CTRL) && apb.pwdata[0] && !busy;
        end
    end

    always_comb
    begin
        case (addr_u.regs.num)
            bus_pkg::REG_STATUS: reg_rdata = {30'd0, done_flag, busy};
            bus_pkg::REG_SIZE:   reg_rdata = 32'(IMG_BITS);
            default:             reg_rdata = '0;
        endcase
    end

    always_comb
    begin
        apb_rsp = '0;
        if (access)
        begin
            if (bad_access)
            begin
                apb_rsp.pready  = 1'b1;
                apb_rsp.pslverr = 1'b1;
            end
            else if (reg_access)
            begin
                apb_rsp.pready = 1'b1;
                apb_rsp.prdata = reg_rdata;
            end
            else if (apb.pwrite)
                apb_rsp.pready = sel_rsp.gnt;
            else
            begin
                apb_rsp.pready = rd_wait && sel_rsp.rvalid;
                apb_rsp.prdata = {24'd0, sel_rsp.rdata};
            end
        end
    end

    // an access phase is always preceded by and paired with a selected slave.
    assert property (@(posedge clk) disable iff (reset) apb.penable |-> apb.psel);

endmodule

`default_nettype wire

// File: logic/simple_ram.sv
`timescale 1ns/1ns
`default_nettype none

module simple_ram #(
    parameter int IMG_BITS = 7
) (
    input  logic              clk,
    input  bus_pkg::mem_req_t mem,
    output lbp_pkg::pixel_t   rdata
);

    localparam int ADDR_BITS = 2 * IMG_BITS;
    localparam int DEPTH     = 2 ** ADDR_BITS;

    lbp_pkg::pixel_t ram [DEPTH];

    // read data appears the cycle after a granted read and holds until the next one.
    always_ff @(posedge clk)
    begin
        if (mem.req)
        begin
            if (mem.we)
                ram[mem.addr[ADDR_BITS-1:0]] <= mem.wdata;
            else
                rdata <= ram[mem.addr[ADDR_BITS-1:0]];
        end
    end

endmodule

`default_nettype wire

// File: logic/mem_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mem_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  bus_pkg::mem_req_t req0,
    input  bus_pkg::mem_req_t req1,
    output bus_pkg::mem_rsp_t rsp0,
    output bus_pkg::mem_rsp_t rsp1,
    output bus_pkg::mem_req_t mem,
    input  lbp_pkg::pixel_t   mem_rdata
);

    logic       last_q;
    logic       grant0;
    logic       grant1;
    logic [1:0] rvalid_q;

    // last_q is set when requester 1 won, so requester 0 has priority next.
    assign grant0 = req0.req && (!req1.req || last_q);
    assign grant1 = req1.req && (!req0.req || !last_q);

    always_comb
    begin
        mem     = grant1 ? req1 : req0;
        mem.req = grant0 || grant1;
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            last_q   <= 1'b0;
            rvalid_q <= 2'b00;
        end
        else
        begin
            if (grant0 || grant1)
                last_q <= grant1;
            rvalid_q <= {grant1 && !req1.we, grant0 && !req0.we};
        end
    end

    assign rsp0.gnt    = grant0;
    assign rsp0.rvalid = rvalid_q[0];
    assign rsp0.rdata  = rvalid_q[0] ? mem_rdata : '0;
    assign rsp1.gnt    = grant1;
    assign rsp1.rvalid = rvalid_q[1];
    assign rsp1.rdata  = rvalid_q[1] ? mem_rdata : '0;

    assert property (@(posedge clk) disable iff (reset) !(rsp0.gnt && rsp1.gnt));

endmodule

`default_nettype wire

// File: lbp/lbp_scanner.sv
`timescale 1ns/1ns
`default_nettype none

module lbp_scanner #(
    parameter int IMG_BITS = 7
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    output logic              busy,
    output logic              done,
    output bus_pkg::mem_req_t fetch_req,
    input  bus_pkg::mem_rsp_t fetch_rsp,
    output bus_pkg::mem_req_t code_req,
    input  bus_pkg::mem_rsp_t code_rsp
);

    localparam logic [IMG_BITS-1:0] LAST = '1;

    typedef enum logic [2:0] {S_IDLE, S_PIXEL, S_FETCH, S_WAIT, S_WRITE} state_t;

    state_t              state;
    logic [IMG_BITS-1:0] row;
    logic [IMG_BITS-1:0] col;
    logic [IMG_BITS-1:0] f_row;
    logic [IMG_BITS-1:0] f_col;
    logic [3:0]          cnt;
    logic                full;
    logic                is_border;
    logic                last_fetch;
    lbp_pkg::nbr_sel_t   cur_slot;
    lbp_pkg::pix_idx_t   pix_idx;
    lbp_pkg::code_t      win_code;

    // full fetch order is centre first, then the neighbours; a short fetch takes the right column.
    function automatic lbp_pkg::nbr_sel_t fetch_slot(input logic all9, input logic [3:0] n);
        if (all9)
            return (n == 4'd0) ? lbp_pkg::SLOT_CENTER : ((n <= 4'd4) ? n - 4'd1 : n);
        return n * 4'd3 + 4'd2;
    endfunction

    assign is_border  = (row == '0) || (row == LAST) || (col == '0) || (col == LAST);
    assign cur_slot   = fetch_slot(full, cnt);
    assign last_fetch = full ? (cnt == 4'd8) : (cnt == 4'd2);
    assign pix_idx    = lbp_pkg::pix_idx_t'({row, col});

    always_comb
    begin
        case (cur_slot)
            4'd0, 4'd1, 4'd2: f_row = row - IMG_BITS'(1);
            4'd6, 4'd7, 4'd8: f_row = row + IMG_BITS'(1);
            default:          f_row = row;
        endcase
        case (cur_slot)
            4'd0, 4'd3, 4'd6: f_col = col - IMG_BITS'(1);
            4'd2, 4'd5, 4'd8: f_col = col + IMG_BITS'(1);
            default:          f_col = col;
        endcase
    end

    assign fetch_req.req   = state == S_FETCH;
    assign fetch_req.we    = 1'b0;
    assign fetch_req.addr  = lbp_pkg::pix_idx_t'({f_row, f_col});
    assign fetch_req.wdata = '0;

    assign code_req.req   = state == S_WRITE;
    assign code_req.we    = 1'b1;
    assign code_req.addr  = pix_idx;
    assign code_req.wdata = is_border ? '0 : win_code;

    lbp_window window (
        .clk   (clk),
        .reset (reset),
        .load  ((state == S_WAIT) && fetch_rsp.rvalid),
        .slot  (cur_slot),
        .data  (fetch_rsp.rdata),
        .shift ((state == S_PIXEL) && !is_border && (col != IMG_BITS'(1))),
        .code  (win_code)
    );

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            row   <= '0;
            col   <= '0;
            cnt   <= '0;
            full  <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (start)
                    begin
                        busy  <= 1'b1;
                        done  <= 1'b0;
                        row   <= '0;
                        col   <= '0;
                        state <= S_PIXEL;
                    end
                S_PIXEL:
                begin
                    cnt   <= '0;
                    full  <= col == IMG_BITS'(1);
                    state <= is_border ? S_WRITE : S_FETCH;
                end
                S_FETCH:
                    if (fetch_rsp.gnt)
                        state <= S_WAIT;
                S_WAIT:
                    if (fetch_rsp.rvalid)
                    begin
                        if (last_fetch)
                            state <= S_WRITE;
                        else
                        begin
                            cnt   <= cnt + 4'd1;
                            state <= S_FETCH;
                        end
                    end
                S_WRITE:
                    if (code_rsp.gnt)
                    begin
                        col <= col + IMG_BITS'(1);
                        if (col == LAST)
                            row <= row + IMG_BITS'(1);
                        if ((col == LAST) && (row == LAST))
                        begin
                            busy  <= 1'b0;
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                        else
                            state <= S_PIXEL;
                    end
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    // a stalled code write keeps pointing at the pixel it belongs to.
    assert property (@(posedge clk) disable iff (reset)
        code_req.req && !code_rsp.gnt |=> code_req.req && code_req.addr == $past(pix_idx));

endmodule

`default_nettype wire

// File: lbp/lbp_window.sv
`timescale 1ns/1ns
`default_nettype none

module lbp_window (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  lbp_pkg::nbr_sel_t slot,
    input  lbp_pkg::pixel_t   data,
    input  logic              shift,
    output lbp_pkg::code_t    code
);

    lbp_pkg::window_t win;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            win <= '0;
        else if (shift)
        begin
            // each row moves one column to the left; the right column is refetched.
            for (int r = 0; r < 3; r++)
            begin
                win[3*r]   <= win[3*r+1];
                win[3*r+1] <= win[3*r+2];
            end
        end
        else if (load)
            win[slot] <= data;
    end

    // the centre slot is skipped, so code bits 4 to 7 come from slots 5 to 8.
    always_comb
    begin
        for (int i = 0; i < lbp_pkg::NUM_NBRS; i++)
            code[i] = win[(i < 4) ? i : i + 1] >= win[lbp_pkg::SLOT_CENTER];
    end

endmodule

`default_nettype wire

// File: common/bus_pkg.sv
`default_nettype none

package bus_pkg;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [15:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // the top two address bits select a region in both views.
    typedef union packed {
        struct packed {
            logic [1:0]        region;
            lbp_pkg::pix_idx_t idx;
        } pix;
        struct packed {
            logic [1:0]  region;
            logic [11:0] unused;
            logic [1:0]  num;
        } regs;
    } apb_addr_u;

    localparam logic [1:0] REGION_REGS = 2'd0;
    localparam logic [1:0] REGION_GRAY = 2'd1;
    localparam logic [1:0] REGION_CODE = 2'd2;
    localparam logic [1:0] REGION_BAD  = 2'd3;

    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;
    localparam logic [1:0] REG_SIZE   = 2'd2;

    typedef struct packed {
        logic              req;
        logic              we;
        lbp_pkg::pix_idx_t addr;
        lbp_pkg::pixel_t   wdata;
    } mem_req_t;

    typedef struct packed {
        logic            gnt;
        logic            rvalid;
        lbp_pkg::pixel_t rdata;
    } mem_rsp_t;

endpackage

`default_nettype wire

// File: common/lbp_pkg.sv
`default_nettype none

package lbp_pkg;

    // largest supported frame is 128x128; smaller frames use only the low index bits.
    localparam int MAX_IMG_BITS = 7;

    localparam int NUM_NBRS = 8;

    typedef logic [7:0] pixel_t;

    // bit 0 is the top-left neighbour, followed by top, top-right, left, right,
    // bottom-left, bottom and bottom-right.
    typedef logic [NUM_NBRS-1:0] code_t;

    // row in the upper half and column in the lower half, IMG_BITS bits each.
    typedef logic [2*MAX_IMG_BITS-1:0] pix_idx_t;

    // window slots run 0 to 8 in raster order over the 3x3 neighbourhood.
    typedef logic [3:0] nbr_sel_t;

    localparam nbr_sel_t SLOT_CENTER = 4'd4;

    typedef pixel_t [8:0] window_t;

endpackage

`default_nettype wire
